// File: bsc_defs.svh
`ifndef BSC_DEFS_SVH
`define BSC_DEFS_SVH

`define BSC_ADDR_W        32
`define BSC_EXT_ADDR_W    27
`define BSC_DATA_W        32
`define BSC_BE_W          4
`define BSC_REG_W         16
`define BSC_CNT_W         8
`define BSC_PRESCALE_BITS 12
`define BSC_AREA_HI       26
`define BSC_AREA_LO       25

`define BSC_KEY      16'hA55A      // Upper data half of a register write
`define BSC_REG_BASE 32'hFFFFFFE0

`define BSC_OFS_BCR1  5'h00
`define BSC_OFS_BCR2  5'h04
`define BSC_OFS_WCR   5'h08
`define BSC_OFS_MCR   5'h0C
`define BSC_OFS_RTCSR 5'h10
`define BSC_OFS_RTCNT 5'h14
`define BSC_OFS_RTCOR 5'h18

`define BSC_BCR1_INIT   16'h03F0
`define BSC_BCR1_WMASK  16'h03F0
`define BSC_BCR1_RMASK  16'h03F0
`define BSC_BCR2_INIT   16'h00FC   // All areas long
`define BSC_BCR2_WMASK  16'h00FC
`define BSC_BCR2_RMASK  16'h00FC
`define BSC_WCR_INIT    16'hAAFF
`define BSC_WCR_WMASK   16'hFFFF
`define BSC_WCR_RMASK   16'hFFFF
`define BSC_MCR_INIT    16'h0000
`define BSC_MCR_WMASK   16'h0004   // Only RFSH is kept
`define BSC_MCR_RMASK   16'h0004
`define BSC_RTCSR_INIT  16'h0000
`define BSC_RTCSR_WMASK 16'h0038
`define BSC_RTCSR_RMASK 16'h0038
`define BSC_RTCNT_INIT  16'h0000
`define BSC_RTCNT_WMASK 16'h00FF
`define BSC_RTCNT_RMASK 16'h00FF
`define BSC_RTCOR_INIT  16'h0000
`define BSC_RTCOR_WMASK 16'h00FF
`define BSC_RTCOR_RMASK 16'h00FF

`define BSC_A0LW_LO  4
`define BSC_A1LW_LO  6
`define BSC_AHLW_LO  8             // Shared by areas 2 and 3
`define BSC_A1SZ_LO  2
`define BSC_A2SZ_LO  4
`define BSC_A3SZ_LO  6
`define BSC_W0_LO    0
`define BSC_W1_LO    2
`define BSC_W2_LO    4
`define BSC_W3_LO    6
`define BSC_RFSH_BIT 2
`define BSC_CKS_LO   3

`endif

// File: bscBusPkg.sv
`include "bsc_defs.svh"

package bscBusPkg;

	typedef logic [`BSC_ADDR_W-1:0]     addrT;
	typedef logic [`BSC_EXT_ADDR_W-1:0] extAddrT;   // External A pins
	typedef logic [`BSC_DATA_W-1:0]     dataT;
	typedef logic [`BSC_BE_W-1:0]       byteEnT;    // Bit 3 is bits 31:24

	typedef logic [1:0] areaT;
	typedef logic [1:0] portSizeT;                  // 01 byte, 10 word, 11 long
	typedef logic [1:0] chunkT;                     // Port-wide piece of a host word

endpackage

// File: bscRegPkg.sv
`include "bsc_defs.svh"

package bscRegPkg;

	typedef logic [`BSC_REG_W-1:0] regHalfT;
	typedef logic [`BSC_CNT_W-1:0] cntT;            // RTCNT and RTCOR

	typedef logic [1:0] waitSelT;                   // One W field of WCR
	typedef logic [2:0] cksT;
	typedef logic [2:0] waitCntT;                   // Up to 6 waits

	typedef logic [`BSC_PRESCALE_BITS-1:0] prescaleT;

endpackage

// File: bscHostPort.sv
`timescale 1ns/1ns
`include "bsc_defs.svh"

module bscHostPort (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              req,
	input  bscBusPkg::addrT   addr,
	input  bscBusPkg::dataT   wdata,
	input  bscBusPkg::byteEnT byteEn,
	input  logic              we,
	input  logic              busDone,
	input  bscBusPkg::dataT   regRdata,
	input  bscBusPkg::dataT   busRdata,
	output logic              ack,
	output bscBusPkg::dataT   rdata,
	output logic              regStrobe,
	output logic              busGo,
	output bscBusPkg::addrT   reqAddr,
	output bscBusPkg::dataT   reqWdata,
	output bscBusPkg::byteEnT reqByteEn,
	output logic              reqWe
);

	typedef enum logic [1:0] {hIdle, hBusy, hHold} hostStateT;

	hostStateT state;
	logic      regPath;
	logic      isReg;
	logic      capture;

	assign isReg   = (addr >= `BSC_REG_BASE);
	assign capture = (state == hIdle) && req && !ack;
	assign rdata   = regPath ? regRdata : busRdata;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= hIdle;
			ack       <= 1'b0;
			regStrobe <= 1'b0;
			busGo     <= 1'b0;
			regPath   <= 1'b0;
		end else begin
			regStrobe <= 1'b0;
			case (state)
				hIdle: begin
					if (capture) begin
						regPath   <= isReg;
						regStrobe <= isReg;
						busGo     <= !isReg;
						state     <= hBusy;
					end
				end
				hBusy: begin
					if (regPath || busDone) begin    // Register data ready one clock after strobe
						busGo <= 1'b0;
						ack   <= 1'b1;
						state <= hHold;
					end
				end
				hHold: begin
					if (!req) begin
						ack   <= 1'b0;
						state <= hIdle;
					end
				end
				default: state <= hIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (capture) begin
			reqAddr   <= addr;
			reqWdata  <= wdata;
			reqByteEn <= byteEn;
			reqWe     <= we;
		end
	end

endmodule

// File: bscRegFile.sv
`timescale 1ns/1ns
`include "bsc_defs.svh"

module bscRegFile (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               regStrobe,
	input  bscBusPkg::addrT    reqAddr,
	input  bscBusPkg::dataT    reqWdata,
	input  logic               reqWe,
	input  logic               rfshAck,
	output bscBusPkg::dataT    regRdata,
	output bscRegPkg::regHalfT bcr1,
	output bscRegPkg::regHalfT bcr2,
	output bscRegPkg::regHalfT wcr,
	output logic               rfshReq
);
	import bscRegPkg::*;

	regHalfT  mcr;
	regHalfT  rtcsr;
	cntT      rtcnt;
	cntT      rtcor;
	regHalfT  wrVal;
	regHalfT  rdVal;
	prescaleT prescale;
	prescaleT tickMask;
	cksT      cks;
	logic     tick;
	logic     wrEn;

	assign wrVal = reqWdata[15:0];
	assign wrEn  = regStrobe && reqWe && (reqWdata[31:16] == `BSC_KEY);
	assign cks   = rtcsr[`BSC_CKS_LO +: 3];

	// Divide by 4, 16, 64, 256, 1024, 2048, 4096
	always_comb begin
		case (cks)
			3'd1: tickMask = prescaleT'(12'h003);
			3'd2: tickMask = prescaleT'(12'h00F);
			3'd3: tickMask = prescaleT'(12'h03F);
			3'd4: tickMask = prescaleT'(12'h0FF);
			3'd5: tickMask = prescaleT'(12'h3FF);
			3'd6: tickMask = prescaleT'(12'h7FF);
			3'd7: tickMask = prescaleT'(12'hFFF);
			default: tickMask = '0;
		endcase
	end

	assign tick = (cks != '0) && ((prescale & tickMask) == tickMask);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bcr1     <= `BSC_BCR1_INIT;
			bcr2     <= `BSC_BCR2_INIT;
			wcr      <= `BSC_WCR_INIT;
			mcr      <= `BSC_MCR_INIT;
			rtcsr    <= `BSC_RTCSR_INIT;
			rtcnt    <= cntT'(`BSC_RTCNT_INIT);
			rtcor    <= cntT'(`BSC_RTCOR_INIT);
			prescale <= '0;
			rfshReq  <= 1'b0;
		end else begin
			prescale <= prescale + 1'b1;
			if (rfshAck)
				rfshReq <= 1'b0;
			if (tick) begin
				if (rtcnt == rtcor) begin
					rtcnt <= '0;
					if (mcr[`BSC_RFSH_BIT])
						rfshReq <= 1'b1;   // New request beats a same-clock ack
				end else begin
					rtcnt <= rtcnt + 1'b1;
				end
			end
			if (wrEn) begin
				case (reqAddr[4:0])
					`BSC_OFS_BCR1:  bcr1  <= wrVal & `BSC_BCR1_WMASK;
					`BSC_OFS_BCR2:  bcr2  <= wrVal & `BSC_BCR2_WMASK;
					`BSC_OFS_WCR:   wcr   <= wrVal & `BSC_WCR_WMASK;
					`BSC_OFS_MCR:   mcr   <= wrVal & `BSC_MCR_WMASK;
					`BSC_OFS_RTCSR: rtcsr <= wrVal & `BSC_RTCSR_WMASK;
					`BSC_OFS_RTCNT: rtcnt <= cntT'(wrVal & `BSC_RTCNT_WMASK);
					`BSC_OFS_RTCOR: rtcor <= cntT'(wrVal & `BSC_RTCOR_WMASK);
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (reqAddr[4:0])
			`BSC_OFS_BCR1:  rdVal = bcr1 & `BSC_BCR1_RMASK;
			`BSC_OFS_BCR2:  rdVal = bcr2 & `BSC_BCR2_RMASK;
			`BSC_OFS_WCR:   rdVal = wcr & `BSC_WCR_RMASK;
			`BSC_OFS_MCR:   rdVal = mcr & `BSC_MCR_RMASK;
			`BSC_OFS_RTCSR: rdVal = rtcsr & `BSC_RTCSR_RMASK;
			`BSC_OFS_RTCNT: rdVal = {8'h00, rtcnt} & `BSC_RTCNT_RMASK;
			`BSC_OFS_RTCOR: rdVal = {8'h00, rtcor} & `BSC_RTCOR_RMASK;
			default: rdVal = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (regStrobe)
			regRdata <= {16'h0000, rdVal};
	end

endmodule

// File: bscCycleCtl.sv
`timescale 1ns/1ns
`include "bsc_defs.svh"

module bscCycleCtl (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               busGo,
	input  bscBusPkg::addrT    reqAddr,
	input  logic               reqWe,
	input  bscRegPkg::regHalfT bcr1,
	input  bscRegPkg::regHalfT wcr,
	input  logic               rfshReq,
	input  logic               chunkLast,
	input  logic               WAIT_N,
	output logic               busDone,
	output logic               rfshAck,
	output logic               chunkStart,
	output logic               chunkNext,
	output logic               BS_N,
	output logic               CS0_N,
	output logic               CS1_N,
	output logic               CS2_N,
	output logic               CS3_N,
	output logic               RD_N,
	output logic               RD_WR_N,
	output logic               RFS
);
	import bscBusPkg::*;
	import bscRegPkg::*;

	typedef enum logic [2:0] {sIdle, sT1, sTw, sT2, sRfshWait, sRfshEnd} cycStateT;

	cycStateT state;
	cycStateT nextState;
	areaT     area;
	waitSelT  wSel;
	waitSelT  lwSel;
	waitCntT  waitLoad;
	waitCntT  waitCnt;
	logic     busCyc;
	logic     rfsCyc;

	assign area = reqAddr[`BSC_AREA_HI:`BSC_AREA_LO];

	always_comb begin
		case (area)
			2'd0: wSel = wcr[`BSC_W0_LO +: 2];
			2'd1: wSel = wcr[`BSC_W1_LO +: 2];
			2'd2: wSel = wcr[`BSC_W2_LO +: 2];
			default: wSel = wcr[`BSC_W3_LO +: 2];
		endcase
		case (area)
			2'd0: lwSel = bcr1[`BSC_A0LW_LO +: 2];
			2'd1: lwSel = bcr1[`BSC_A1LW_LO +: 2];
			default: lwSel = bcr1[`BSC_AHLW_LO +: 2];
		endcase
		if (wSel == 2'd3)
			waitLoad = waitCntT'(lwSel) + waitCntT'(3);   // Long wait gives 3 to 6
		else
			waitLoad = waitCntT'(wSel);
	end

	always_comb begin
		nextState = state;
		case (state)
			sIdle: begin
				if (rfshReq)
					nextState = sRfshWait;
				else if (busGo)
					nextState = sT1;
			end
			sT1: nextState = (waitLoad == '0) ? sT2 : sTw;
			sTw: begin
				if (WAIT_N && waitCnt == waitCntT'(1))
					nextState = sT2;
			end
			sT2: nextState = chunkLast ? sIdle : sT1;   // Next chunk goes straight to T1
			sRfshWait: begin
				if (waitCnt == '0)
					nextState = sRfshEnd;
			end
			sRfshEnd: nextState = sIdle;
			default: nextState = sIdle;
		endcase
	end

	assign chunkStart = (state == sIdle) && !rfshReq && busGo;
	assign chunkNext  = (state == sT2);
	assign busDone    = chunkNext && chunkLast;
	assign rfshAck    = (state == sRfshEnd);

	assign busCyc = (nextState == sT1) || (nextState == sTw) || (nextState == sT2);
	assign rfsCyc = (nextState == sRfshWait) || (nextState == sRfshEnd);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state   <= sIdle;
			waitCnt <= '0;
			BS_N    <= 1'b1;
			CS0_N   <= 1'b1;
			CS1_N   <= 1'b1;
			CS2_N   <= 1'b1;
			CS3_N   <= 1'b1;
			RD_N    <= 1'b1;
			RD_WR_N <= 1'b1;
			RFS     <= 1'b0;
		end else begin
			state <= nextState;
			case (state)
				sIdle: waitCnt <= waitCntT'(1);   // Two refresh-wait clocks
				sT1:   waitCnt <= waitLoad;
				sTw: begin
					if (WAIT_N && waitCnt != waitCntT'(1))
						waitCnt <= waitCnt - 1'b1;   // WAIT_N low holds the count
				end
				sRfshWait: begin
					if (waitCnt != '0)
						waitCnt <= waitCnt - 1'b1;
				end
				default: ;
			endcase
			BS_N    <= (nextState != sT1);
			CS0_N   <= !(busCyc && area == 2'd0);
			CS1_N   <= !(busCyc && area == 2'd1);
			CS2_N   <= !(busCyc && area == 2'd2);
			CS3_N   <= !((busCyc && area == 2'd3) || rfsCyc);
			RD_N    <= !(busCyc && !reqWe);
			RD_WR_N <= !(busCyc && reqWe);
			RFS     <= rfsCyc;
		end
	end

endmodule

// File: bscLaneSteer.sv
`timescale 1ns/1ns
`include "bsc_defs.svh"

module bscLaneSteer (
	input  logic               CLK,
	input  logic               RST_N,
	input  bscBusPkg::addrT    reqAddr,
	input  bscBusPkg::dataT    reqWdata,
	input  bscBusPkg::byteEnT  reqByteEn,
	input  logic               reqWe,
	input  bscRegPkg::regHalfT bcr2,
	input  logic               chunkStart,
	input  logic               chunkNext,
	input  bscBusPkg::dataT    DI,
	output bscBusPkg::extAddrT A,
	output bscBusPkg::dataT    DO,
	output bscBusPkg::byteEnT  WE_N,
	output logic               chunkLast,
	output bscBusPkg::dataT    busRdata
);
	import bscBusPkg::*;

	function automatic byteEnT chunkMask(input portSizeT sz, input chunkT idx);
		case (sz)
			2'b01: return byteEnT'(4'b1000 >> idx);
			2'b10: return idx[0] ? 4'b0011 : 4'b1100;
			default: return 4'b1111;
		endcase
	endfunction

	// Valid bit and index of the first enabled chunk at or after from
	function automatic logic [2:0] findChunk(input portSizeT sz, input byteEnT be,
			input logic [2:0] from);
		logic [2:0] hit;
		int lastIdx;
		hit = '0;
		lastIdx = (sz == 2'b01) ? 3 : (sz == 2'b10) ? 1 : 0;
		for (int i = 3; i >= 0; i--) begin
			if (i >= from && i <= lastIdx && |(be & chunkMask(sz, chunkT'(i))))
				hit = {1'b1, 2'(i)};
		end
		return hit;
	endfunction

	function automatic logic [1:0] chunkShift(input portSizeT sz, input chunkT idx);
		case (sz)
			2'b01: return 2'd3 - idx;
			2'b10: return idx[0] ? 2'd0 : 2'd2;
			default: return 2'd0;
		endcase
	endfunction

	function automatic logic [1:0] chunkOfs(input portSizeT sz, input chunkT idx);
		case (sz)
			2'b01: return idx;
			2'b10: return {idx[0], 1'b0};
			default: return 2'b00;
		endcase
	endfunction

	function automatic dataT widthMask(input portSizeT sz);
		case (sz)
			2'b01: return dataT'(32'h0000_00FF);
			2'b10: return dataT'(32'h0000_FFFF);
			default: return '1;
		endcase
	endfunction

	portSizeT   portSize;
	chunkT      cur;
	chunkT      loadIdx;
	logic [2:0] firstHit;
	logic [2:0] nextHit;
	logic [1:0] loadShift;
	logic [1:0] curShift;
	byteEnT     loadLanes;
	byteEnT     curLanes;
	dataT       curBits;
	logic       loadEn;

	always_comb begin
		case (reqAddr[`BSC_AREA_HI:`BSC_AREA_LO])
			2'd1: portSize = bcr2[`BSC_A1SZ_LO +: 2];
			2'd2: portSize = bcr2[`BSC_A2SZ_LO +: 2];
			2'd3: portSize = bcr2[`BSC_A3SZ_LO +: 2];
			default: portSize = 2'b11;   // Area 0 is always long
		endcase
	end

	assign firstHit  = findChunk(portSize, reqByteEn, 3'd0);
	assign nextHit   = findChunk(portSize, reqByteEn, {1'b0, cur} + 3'd1);
	assign chunkLast = !nextHit[2];
	assign loadIdx   = chunkStart ? firstHit[1:0] : nextHit[1:0];
	assign loadEn    = chunkStart || (chunkNext && !chunkLast);
	assign loadShift = chunkShift(portSize, loadIdx);
	assign loadLanes = reqByteEn & chunkMask(portSize, loadIdx);
	assign curShift  = chunkShift(portSize, cur);
	assign curLanes  = reqByteEn & chunkMask(portSize, cur);
	assign curBits   = {{8{curLanes[3]}}, {8{curLanes[2]}}, {8{curLanes[1]}}, {8{curLanes[0]}}};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cur  <= '0;
			WE_N <= '1;
		end else if (loadEn) begin
			cur  <= loadIdx;
			WE_N <= ~(({4{reqWe}} & loadLanes) >> loadShift);
		end else if (chunkNext) begin
			WE_N <= '1;
		end
	end

	always_ff @(posedge CLK) begin
		if (loadEn) begin
			A  <= {reqAddr[26:2], chunkOfs(portSize, loadIdx)};
			DO <= (reqWdata >> {loadShift, 3'b000}) & widthMask(portSize);
		end
		if (chunkStart)
			busRdata <= '0;   // Disabled lanes read zero
		else if (chunkNext)
			busRdata <= busRdata | (((DI & widthMask(portSize)) << {curShift, 3'b000}) & curBits);
	end

endmodule

// File: bscTop.sv
`timescale 1ns/1ns

module bscTop (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               req,
	input  bscBusPkg::addrT    addr,
	input  bscBusPkg::dataT    wdata,
	input  bscBusPkg::byteEnT  byteEn,
	input  logic               we,
	output logic               ack,
	output bscBusPkg::dataT    rdata,
	output bscBusPkg::extAddrT A,
	input  bscBusPkg::dataT    DI,
	output bscBusPkg::dataT    DO,
	output logic               BS_N,
	output logic               CS0_N,
	output logic               CS1_N,
	output logic               CS2_N,
	output logic               CS3_N,
	output logic               RD_WR_N,
	output logic               RD_N,
	output bscBusPkg::byteEnT  WE_N,
	input  logic               WAIT_N,
	output logic               RFS
);
	import bscBusPkg::*;
	import bscRegPkg::*;

	logic    regStrobe;
	logic    busGo;
	logic    busDone;
	addrT    reqAddr;
	dataT    reqWdata;
	byteEnT  reqByteEn;
	logic    reqWe;
	dataT    regRdata;
	dataT    busRdata;
	regHalfT bcr1;
	regHalfT bcr2;
	regHalfT wcr;
	logic    rfshReq;
	logic    rfshAck;
	logic    chunkStart;
	logic    chunkNext;
	logic    chunkLast;

	bscHostPort i_hostPort (.*);

	bscRegFile i_regFile (.*);

	bscCycleCtl i_cycleCtl (.*);

	bscLaneSteer i_laneSteer (.*);   // Address, data lanes and read assembly

endmodule

// File: bscTb.sv
`timescale 1ns/1ns
`include "bsc_defs.svh"

module bscTb;
	import bscBusPkg::*;
	import bscRegPkg::*;

	localparam int cmpNone = 0;
	localparam int cmpData = 1;
	localparam int cmpReg  = 2;
	localparam int accessCount   = 200;
	localparam int longestAccess = 40;      // Clocks including handshake and long waits
	localparam int watchdogNs = (16 + accessCount * longestAccess + 8 * 40) * 20;

	logic    CLK;
	logic    RST_N;
	logic    req;
	addrT    addr;
	dataT    wdata;
	byteEnT  byteEn;
	logic    we;
	logic    ack;
	dataT    rdata;
	extAddrT A;
	dataT    DI;
	dataT    DO;
	logic    BS_N;
	logic    CS0_N;
	logic    CS1_N;
	logic    CS2_N;
	logic    CS3_N;
	logic    RD_WR_N;
	logic    RD_N;
	byteEnT  WE_N;
	logic    WAIT_N;
	logic    RFS;

	integer  seed = 32'h496ac71b;
	logic [7:0] extMem [0:255];             // {area, A[5:0]}
	logic [7:0] refMem [0:255];
	int      areaWidth [4];
	areaT    activeArea = '0;
	int      strobeClks = 0;
	int      busCycles = 0;
	byteEnT  laneAcc = '0;
	int      waitHold = 0;
	int      waitLeft = 0;
	int      ackWait;
	int      lastStrobe;
	int      lastCycles;
	int      expKind [$];
	dataT    expData [$];
	logic    ackPrev = 1'b0;
	int      clkCount = 0;
	int      lastRise = -1;
	int      rfsWidth = 0;
	logic    rfsPrev = 1'b0;
	int      rfsPeriods [$];
	int      rfsWidths [$];

	bscTop i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic stopRun();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input dataT got, input dataT exp);
		if (got !== exp) begin
			$display("FAIL @%0t %s: got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkHalf(input string name, input regHalfT got, input regHalfT exp);
		if (got !== exp) begin
			$display("FAIL @%0t %s: got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL @%0t %s: got %0d expected %0d", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkLanes(input string name, input byteEnT got, input byteEnT exp);
		if (got !== exp) begin
			$display("FAIL @%0t %s: got %b expected %b", $time, name, got, exp);
			stopRun();
		end
	endtask

	// Host view of memory with lane 3 at the lowest byte address
	function automatic dataT expectedRead(input areaT ar, input addrT ad, input byteEnT be,
			input int w);
		dataT r;
		int   lane;
		r = '0;
		for (int c = 0; c < 4; c += w) begin
			for (int k = 0; k < w; k++) begin
				lane = 3 - (c + k);
				if (be[lane])
					r[8*lane +: 8] = refMem[{ar, ad[5:2], 2'(c + k)}];
			end
		end
		return r;
	endfunction

	function automatic int chunkCount(input int w, input byteEnT be);
		case (w)
			1: return int'(be[3]) + int'(be[2]) + int'(be[1]) + int'(be[0]);
			2: return int'(|be[3:2]) + int'(|be[1:0]);
			default: return int'(|be);
		endcase
	endfunction

	function automatic int waitsFor(input areaT ar, input regHalfT w, input regHalfT b1);
		waitSelT sel;
		waitSelT lw;
		case (ar)
			2'd0: sel = w[`BSC_W0_LO +: 2];
			2'd1: sel = w[`BSC_W1_LO +: 2];
			2'd2: sel = w[`BSC_W2_LO +: 2];
			default: sel = w[`BSC_W3_LO +: 2];
		endcase
		case (ar)
			2'd0: lw = b1[`BSC_A0LW_LO +: 2];
			2'd1: lw = b1[`BSC_A1LW_LO +: 2];
			default: lw = b1[`BSC_AHLW_LO +: 2];   // Areas 2 and 3 share it
		endcase
		return (sel == 2'd3) ? int'(lw) + 3 : int'(sel);
	endfunction

	function automatic logic [4:0] regOffset(input int i);
		case (i)
			0: return `BSC_OFS_RTCOR;
			1: return `BSC_OFS_RTCNT;
			2: return `BSC_OFS_RTCSR;
			3: return `BSC_OFS_MCR;
			4: return `BSC_OFS_WCR;
			5: return `BSC_OFS_BCR2;
			default: return `BSC_OFS_BCR1;
		endcase
	endfunction

	function automatic regHalfT regMask(input int i);
		case (i)
			0: return `BSC_RTCOR_WMASK & `BSC_RTCOR_RMASK;
			1: return `BSC_RTCNT_WMASK & `BSC_RTCNT_RMASK;
			2: return `BSC_RTCSR_WMASK & `BSC_RTCSR_RMASK;
			3: return `BSC_MCR_WMASK & `BSC_MCR_RMASK;
			4: return `BSC_WCR_WMASK & `BSC_WCR_RMASK;
			5: return `BSC_BCR2_WMASK & `BSC_BCR2_RMASK;
			default: return `BSC_BCR1_WMASK & `BSC_BCR1_RMASK;
		endcase
	endfunction

	function automatic byteEnT randomEnables();
		byteEnT be;
		be = byteEnT'($random(seed));
		return (be == '0) ? 4'h1 : be;
	endfunction

	function automatic addrT areaAddr(input areaT ar, input int word);
		return {5'h00, ar, 19'h0, 4'(word), 2'b00};
	endfunction

	task automatic hostAccess(input addrT ad, input dataT wd, input byteEnT be, input logic wr,
			input int kind, input dataT exp);
		int startStrobe;
		int startCyc;
		@(negedge CLK);
		expKind.push_back(kind);
		expData.push_back(exp);
		laneAcc = '0;
		startStrobe = strobeClks;
		startCyc = busCycles;
		addr = ad;
		wdata = wd;
		byteEn = be;
		we = wr;
		req = 1'b1;
		@(negedge CLK);
		ackWait = 1;
		while (!ack) begin
			@(negedge CLK);
			ackWait++;
		end
		req = 1'b0;
		lastStrobe = strobeClks - startStrobe;
		lastCycles = busCycles - startCyc;
		while (ack)
			@(negedge CLK);
	endtask

	task automatic writeReg(input logic [4:0] ofs, input regHalfT val, input regHalfT upper);
		hostAccess(`BSC_REG_BASE + addrT'(ofs), {upper, val}, 4'hF, 1'b1, cmpNone, '0);
		checkCount("register ack latency", ackWait, 2);
	endtask

	task automatic readReg(input logic [4:0] ofs, input regHalfT exp);
		hostAccess(`BSC_REG_BASE + addrT'(ofs), '0, 4'hF, 1'b0, cmpReg, {16'h0000, exp});
		checkCount("register ack latency", ackWait, 2);
	endtask

	task automatic busWrite(input areaT ar, input int word, input dataT d, input byteEnT be);
		for (int k = 0; k < 4; k++) begin
			if (be[3 - k])
				refMem[{ar, 4'(word), 2'(k)}] = d[8*(3 - k) +: 8];
		end
		activeArea = ar;
		hostAccess(areaAddr(ar, word), d, be, 1'b1, cmpNone, '0);
		checkCount("bus cycles", lastCycles, chunkCount(areaWidth[ar], be));
		checkLanes("WE_N lanes", laneAcc, be);
	endtask

	task automatic busRead(input areaT ar, input int word, input byteEnT be);
		dataT exp;
		exp = expectedRead(ar, areaAddr(ar, word), be, areaWidth[ar]);
		activeArea = ar;
		hostAccess(areaAddr(ar, word), '0, be, 1'b0, cmpData, exp);
		checkCount("bus cycles", lastCycles, chunkCount(areaWidth[ar], be));
		checkLanes("WE_N lanes", laneAcc, 4'h0);
	endtask

	// Counts strobe clocks and written host lanes
	always @(negedge CLK) begin : busMonitor
		int ofs;
		if (!RD_N || !RD_WR_N)
			strobeClks++;
		if (!BS_N) begin
			busCycles++;
			if ({CS3_N, CS2_N, CS1_N, CS0_N} != ~(4'b0001 << activeArea)) begin
				$display("Wrong chip select low in T1 for area %0d", activeArea);
				stopRun();
			end
			for (int j = 0; j < 4; j++) begin
				ofs = int'(A[1:0]) + areaWidth[activeArea] - 1 - j;
				if (!WE_N[j])
					laneAcc[3 - ofs] = 1'b1;
			end
		end
	end

	// External memory of all areas with WAIT_N stretch
	always @(negedge CLK) begin : extMemory
		int   w;
		int   ofs;
		dataT rd;
		w = areaWidth[activeArea];
		if (!BS_N) begin
			waitLeft = waitHold;
			WAIT_N <= 1'b1;
		end else if ((!RD_N || !RD_WR_N) && waitLeft > 0) begin
			WAIT_N <= 1'b0;
			waitLeft--;
		end else begin
			WAIT_N <= 1'b1;
		end
		rd = '0;
		for (int j = 0; j < w; j++) begin
			ofs = int'(A[5:0]) + w - 1 - j;
			rd[8*j +: 8] = extMem[{activeArea, 6'(ofs)}];
			if (!RD_WR_N && !WE_N[j])
				extMem[{activeArea, 6'(ofs)}] = DO[8*j +: 8];
		end
		DI <= rd;
	end

	always @(negedge CLK) begin : refreshMonitor
		clkCount++;
		if (RFS && !rfsPrev) begin
			if (lastRise >= 0)
				rfsPeriods.push_back(clkCount - lastRise);
			lastRise = clkCount;
			rfsWidth = 0;
		end
		if (RFS) begin
			rfsWidth++;
			if (CS3_N) begin
				$display("CS3_N was high during a refresh cycle");
				stopRun();
			end
		end
		if (!RFS && rfsPrev)
			rfsWidths.push_back(rfsWidth);
		rfsPrev = RFS;
	end

	always @(negedge CLK) begin : compareProc
		int   kind;
		dataT exp;
		if (ack && !ackPrev) begin
			if (expKind.size() == 0) begin
				$display("ack rose with no access outstanding");
				stopRun();
			end else begin
				kind = expKind.pop_front();
				exp = expData.pop_front();
				if (kind == cmpData) begin
					checkData("rdata", rdata, exp);
				end else if (kind == cmpReg) begin
					checkHalf("rdata[15:0]", rdata[15:0], exp[15:0]);
					checkHalf("rdata[31:16]", rdata[31:16], 16'h0000);
				end
			end
		end
		ackPrev = ack;
	end

	initial begin : watchdog
		#(watchdogNs);
		$display("Watchdog expired, the tests did not finish within %0d ns", watchdogNs);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	initial begin : mainSeq
		regHalfT val;
		regHalfT upper;
		regHalfT wcrVal;
		regHalfT bcr1Val;
		dataT    d;
		int      n;
		int      n0;
		RST_N = 1'b0;
		req = 1'b0;
		addr = '0;
		wdata = '0;
		byteEn = '0;
		we = 1'b0;
		DI = '0;
		WAIT_N = 1'b1;
		for (int i = 0; i < 4; i++)
			areaWidth[i] = 4;
		for (int i = 0; i < 256; i++) begin
			extMem[i] = 8'(i * 29 + 60);
			refMem[i] = 8'(i * 29 + 60);
		end
		repeat (16) @(negedge CLK);
		if ({BS_N, CS0_N, CS1_N, CS2_N, CS3_N, RD_N, RD_WR_N} != 7'h7F || WE_N != 4'hF
				|| RFS || ack) begin
			$display("Outputs are not at their reset values during reset");
			stopRun();
		end
		RST_N = 1'b1;

		// Keyed and unkeyed register writes with RTCNT before the timer runs
		for (int i = 0; i < 7; i++) begin
			val = regHalfT'($random(seed));
			writeReg(regOffset(i), val, `BSC_KEY);
			readReg(regOffset(i), val & regMask(i));
			upper = regHalfT'($random(seed));
			if (upper == `BSC_KEY)
				upper = upper ^ 16'h0001;
			writeReg(regOffset(i), ~val, upper);
			readReg(regOffset(i), val & regMask(i));
		end
		writeReg(`BSC_OFS_MCR, 16'h0000, `BSC_KEY);
		writeReg(`BSC_OFS_RTCSR, 16'h0000, `BSC_KEY);

		writeReg(`BSC_OFS_BCR2, 16'h00E4, `BSC_KEY);   // Area 1 byte, 2 word, 3 long
		areaWidth[1] = 1;
		areaWidth[2] = 2;
		wcrVal = 16'h0000;
		writeReg(`BSC_OFS_WCR, wcrVal, `BSC_KEY);

		for (int i = 0; i < 8; i++)
			busWrite(2'd0, i, dataT'($random(seed)), randomEnables());
		for (int i = 0; i < 8; i++)
			busRead(2'd0, i, 4'hF);

		for (int ar = 1; ar < 4; ar++) begin
			for (int i = 0; i < 6; i++) begin
				busWrite(areaT'(ar), i, dataT'($random(seed)), randomEnables());
				busRead(areaT'(ar), i, randomEnables());
				busRead(areaT'(ar), i, 4'hF);
			end
		end

		// Wait selection sweep with a single chunk per access
		for (int ar = 0; ar < 4; ar++) begin
			for (int sel = 0; sel < 4; sel++) begin
				wcrVal = regHalfT'(sel) << (2 * ar);
				bcr1Val = regHalfT'($random(seed)) & `BSC_BCR1_WMASK;
				writeReg(`BSC_OFS_WCR, wcrVal, `BSC_KEY);
				writeReg(`BSC_OFS_BCR1, bcr1Val, `BSC_KEY);
				busRead(areaT'(ar), ar * 4 + sel, 4'b1000);
				checkCount("strobe clocks", lastStrobe, 2 + waitsFor(areaT'(ar), wcrVal, bcr1Val));
			end
		end

		for (int k = 1; k <= 4; k++) begin
			n = 1 + k % 2;
			wcrVal = regHalfT'(n);
			writeReg(`BSC_OFS_WCR, wcrVal, `BSC_KEY);
			waitHold = k;
			busRead(2'd0, k, 4'hF);
			checkCount("strobe clocks with WAIT_N", lastStrobe, 2 + n + k);
			d = dataT'($random(seed));
			busWrite(2'd0, k + 8, d, 4'hF);
			checkCount("strobe clocks with WAIT_N", lastStrobe, 2 + n + k);
			waitHold = 0;
			busRead(2'd0, k + 8, 4'hF);
		end

		// Refresh every 4 * (RTCOR + 1) clocks with CKS 1
		writeReg(`BSC_OFS_RTCOR, 16'd9, `BSC_KEY);
		writeReg(`BSC_OFS_RTCNT, 16'd0, `BSC_KEY);
		writeReg(`BSC_OFS_RTCSR, regHalfT'(1) << `BSC_CKS_LO, `BSC_KEY);
		writeReg(`BSC_OFS_MCR, regHalfT'(1) << `BSC_RFSH_BIT, `BSC_KEY);
		n0 = rfsPeriods.size();
		while (rfsPeriods.size() < n0 + 4)
			@(negedge CLK);
		for (int i = n0 + 1; i < n0 + 4; i++)
			checkCount("RFS period", rfsPeriods[i], 4 * (9 + 1));
		for (int i = 0; i < rfsWidths.size(); i++)
			checkCount("RFS width", rfsWidths[i], 3);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
bscBusPkg.sv
bscRegPkg.sv
bscHostPort.sv
bscRegFile.sv
bscCycleCtl.sv
bscLaneSteer.sv
bscTop.sv
bscTb.sv
